// File: can_rx_decoder.f
verilog/can_pkg.sv
verilog/can_destuff.sv
verilog/can_crc15.sv
verilog/can_frame_fsm.sv
verilog/can_field_capture.sv
verilog/can_rx_decoder.sv
+incdir+verif
verif/can_rx_decoder_tb.sv

// File: verif/can_frame_gen.svh
`ifndef CAN_FRAME_GEN_SVH
`define CAN_FRAME_GEN_SVH

// ======================================================================
// Frame bit stream builder
// ======================================================================
logic        frame_bits[$];  // Bus levels, SOF first
logic        raw_bits[$];    // Frame content before stuffing
logic [14:0] frame_crc;      // CRC as sent, corruption included
int          stuff_count;    // Stuff bits in the last frame

// One CRC-15 step, x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
function automatic logic [14:0] crc15_next(input logic [14:0] crc, input logic b);
	logic [14:0] shifted;
	shifted = {crc[13:0], 1'b0};
	if (b ^ crc[14])
		return shifted ^ 15'h4599;
	return shifted;
endfunction

// MSB first, width may be zero
function automatic void append_field(input logic [63:0] value, input int width);
	for (int i = width - 1; i >= 0; i--)
		raw_bits.push_back(value[i]);
endfunction

function automatic void build_frame(
	input logic [10:0] ident_a,
	input logic [17:0] ident_b,
	input logic        ext,
	input logic        rtr_bit,
	input logic [3:0]  dlc_code,
	input logic [63:0] payload,    // Sent bytes in the low bits, first byte highest
	input logic [14:0] crc_flip,   // Bits of the CRC to corrupt
	input logic        crc_delim   // Recessive unless a form error is wanted
);
	int          nbytes;
	logic [14:0] crc;
	logic        run_val;
	int          run_len;

	raw_bits.delete();
	raw_bits.push_back(1'b0);  // SOF
	append_field(64'(ident_a), 11);
	if (ext)
	begin
		raw_bits.push_back(1'b1);  // SRR
		raw_bits.push_back(1'b1);  // IDE
		append_field(64'(ident_b), 18);
		raw_bits.push_back(rtr_bit);
		raw_bits.push_back(1'b0);  // r1
	end
	else
	begin
		raw_bits.push_back(rtr_bit);
		raw_bits.push_back(1'b0);  // IDE, base frame
	end
	raw_bits.push_back(1'b0);  // r0
	append_field(64'(dlc_code), 4);
	nbytes = rtr_bit ? 0 : ((dlc_code > MAX_BYTES) ? MAX_BYTES : dlc_code);
	append_field(payload, 8 * nbytes);

	// CRC over SOF through data
	crc = '0;
	foreach (raw_bits[i])
		crc = crc15_next(crc, raw_bits[i]);
	frame_crc = crc ^ crc_flip;
	append_field(64'(frame_crc), 15);

	// Stuffing runs from SOF to the last CRC bit
	frame_bits.delete();
	stuff_count = 0;
	run_val     = 1'b1;
	run_len     = 0;
	foreach (raw_bits[i])
	begin
		frame_bits.push_back(raw_bits[i]);
		if (raw_bits[i] == run_val)
			run_len++;
		else
		begin
			run_val = raw_bits[i];
			run_len = 1;
		end
		if (run_len == 5)
		begin
			frame_bits.push_back(!run_val);  // Stuff bit starts a new run
			run_val = !run_val;
			run_len = 1;
			stuff_count++;
		end
	end

	frame_bits.push_back(crc_delim);
	frame_bits.push_back(1'b0);  // ACK slot, acknowledged
	frame_bits.push_back(1'b1);  // ACK delimiter
	repeat (7) frame_bits.push_back(1'b1);  // EOF
	repeat (3) frame_bits.push_back(1'b1);  // Intermission, then idle
endfunction

`endif

// File: verif/can_rx_decoder_tb.sv
`timescale 1ns/1ns

module can_rx_decoder_tb;

	localparam int MAX_BYTES   = 8;
	localparam int TEST_BITS   = 6 * 200;             // Six tests, each under 200 bit times
	localparam int CYCLE_LIMIT = 4 * TEST_BITS + 400; // Four clocks per bit, plus reset

	logic                 clock;
	logic                 reset;
	logic                 rx_bit;
	logic                 sample_point;
	logic [10:0]          id_a;
	logic [17:0]          id_b;
	logic                 ide;
	logic                 srr;
	logic                 rtr;
	logic [3:0]           dlc;
	logic [63:0]          data;
	logic [14:0]          crc_received;
	logic                 frame_done;
	logic                 frame_error;
	can_pkg::error_kind_t error_kind;

	string                test_name;
	int                   error_count = 0;
	int                   errors_at_start;
	int                   test_count = 0;
	int                   failed_tests = 0;
	int                   cycle_count = 0;
	integer               seed;
	logic                 seen_done;     // Sticky over one send
	logic                 seen_error;
	can_pkg::error_kind_t seen_kind;     // Kind at the first error pulse

	`include "can_frame_gen.svh"

	can_rx_decoder #(
		.MAX_DATA_BYTES (MAX_BYTES)
	) can_rx_decoder_inst (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.id_a         (id_a),
		.id_b         (id_b),
		.ide          (ide),
		.srr          (srr),
		.rtr          (rtr),
		.dlc          (dlc),
		.data         (data),
		.crc_received (crc_received),
		.frame_done   (frame_done),
		.frame_error  (frame_error),
		.error_kind   (error_kind)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Hang guard
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT)
		begin
			$display("Timeout, run stopped after %0d cycles", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	// ======================================================================
	// Bit driving and checks
	// ======================================================================
	// Four clocks per bit, sample strobe on the first
	task automatic drive_bit(input logic b);
		@(posedge clock);
		#1;
		rx_bit       = b;
		sample_point = 1'b1;
		@(posedge clock);
		#1;
		sample_point = 1'b0;
		if (frame_done)
			seen_done = 1'b1;
		if (frame_error && !seen_error)
		begin
			seen_error = 1'b1;
			seen_kind  = error_kind;
		end
		repeat (2) @(posedge clock);
	endtask

	// Whole stream, cut short at the first error
	task automatic send_frame();
		int idx;
		seen_done  = 1'b0;
		seen_error = 1'b0;
		idx        = 0;
		while (idx < frame_bits.size() && !seen_error)
		begin
			drive_bit(frame_bits[idx]);
			idx++;
		end
	endtask

	task automatic send_recovery();
		seen_done  = 1'b0;
		seen_error = 1'b0;
		repeat (6) drive_bit(1'b0);  // Error flag
		repeat (8) drive_bit(1'b1);  // Error delimiter
		repeat (4) drive_bit(1'b1);  // Intermission and idle
		check_true(!seen_error && !seen_done, "unexpected pulse during error recovery");
	endtask

	task automatic check_value(input string field, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
		else
		begin
			$display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h",
				test_name, field, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1)
		else
		begin
			$display("%s: %s", test_name, what);
			error_count++;
		end
	endtask

	task automatic check_fields(input logic [10:0] exp_id_a, input logic [17:0] exp_id_b,
		input logic exp_ide, input logic exp_srr, input logic exp_rtr,
		input logic [3:0] exp_dlc, input logic [63:0] exp_data);
		check_value("id_a", 64'(exp_id_a), 64'(id_a));
		check_value("id_b", 64'(exp_id_b), 64'(id_b));
		check_value("ide", 64'(exp_ide), 64'(ide));
		check_value("srr", 64'(exp_srr), 64'(srr));
		check_value("rtr", 64'(exp_rtr), 64'(rtr));
		check_value("dlc", 64'(exp_dlc), 64'(dlc));
		check_value("data", exp_data, data);
		check_value("crc_received", 64'(frame_crc), 64'(crc_received));
	endtask

	task automatic begin_test(input string name);
		test_name       = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		test_count++;
		if (error_count == errors_at_start)
			$display("%s: passed", test_name);
		else
		begin
			$display("%s: failed", test_name);
			failed_tests++;
		end
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================
	task automatic test_base_data_frame();
		logic [63:0] payload;
		begin_test("base_data_frame");
		payload = {40'h0, 24'($random(seed))};
		build_frame(11'h7F0, 18'h0, 1'b0, 1'b0, 4'd3, payload, 15'h0, 1'b1);  // Long ones run
		check_true(stuff_count > 0, "identifier produced no stuff bits");
		send_frame();
		check_true(seen_done, "no frame_done seen");
		check_true(!seen_error, "frame_error on a correct frame");
		check_fields(11'h7F0, 18'h0, 1'b0, 1'b0, 1'b0, 4'd3, payload);
		end_test();
	endtask

	task automatic test_extended_remote_frame();
		begin_test("extended_remote_frame");
		build_frame(11'h2A5, 18'h3C0F1, 1'b1, 1'b1, 4'd2, 64'h0, 15'h0, 1'b1);
		send_frame();
		check_true(seen_done, "no frame_done seen");
		check_true(!seen_error, "frame_error on a correct frame");
		check_fields(11'h2A5, 18'h3C0F1, 1'b1, 1'b1, 1'b1, 4'd2, 64'h0);  // No data taken
		end_test();
	endtask

	task automatic test_dlc_clamp();
		logic [63:0] payload;
		begin_test("dlc_clamp");
		payload = {$random(seed), $random(seed)};
		build_frame(11'h123, 18'h0, 1'b0, 1'b0, 4'd12, payload, 15'h0, 1'b1);
		send_frame();
		check_true(seen_done, "no frame_done seen");
		check_true(!seen_error, "frame_error on a correct frame");
		check_fields(11'h123, 18'h0, 1'b0, 1'b0, 1'b0, 4'd8, payload);
		end_test();
	endtask

	task automatic test_crc_error();
		begin_test("crc_error");
		build_frame(11'h456, 18'h0, 1'b0, 1'b0, 4'd2, 64'hBEEF, 15'h0010, 1'b1);
		send_frame();
		check_true(seen_error, "no frame_error seen after a corrupted CRC");
		check_true(!seen_done, "frame_done on a frame with a bad CRC");
		check_value("error_kind", 64'(can_pkg::ERR_CRC), 64'(seen_kind));
		send_recovery();
		end_test();
	endtask

	task automatic test_stuff_error_recovery();
		begin_test("stuff_error_recovery");
		frame_bits = {1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};  // SOF, six ones
		send_frame();
		check_true(seen_error, "no frame_error seen after six equal bits");
		check_value("error_kind", 64'(can_pkg::ERR_STUFF), 64'(seen_kind));
		send_recovery();
		build_frame(11'h555, 18'h0, 1'b0, 1'b0, 4'd1, 64'hA7, 15'h0, 1'b1);
		send_frame();
		check_true(seen_done, "no frame_done seen after recovery");
		check_true(!seen_error, "frame_error on the frame after recovery");
		check_fields(11'h555, 18'h0, 1'b0, 1'b0, 1'b0, 4'd1, 64'hA7);
		check_value("error_kind", 64'(can_pkg::ERR_NONE), 64'(error_kind));  // Cleared at SOF
		end_test();
	endtask

	task automatic test_form_error();
		begin_test("form_error");
		build_frame(11'h0F3, 18'h0, 1'b0, 1'b0, 4'd1, 64'h5C, 15'h0, 1'b0);  // Dominant delim
		send_frame();
		check_true(seen_error, "no frame_error seen after a dominant CRC delimiter");
		check_true(!seen_done, "frame_done on a frame with a form error");
		check_value("error_kind", 64'(can_pkg::ERR_FORM), 64'(seen_kind));
		send_recovery();
		end_test();
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial
	begin
		seed         = 32'hc302;
		reset        = 1'b1;
		rx_bit       = 1'b1;  // Recessive idle bus
		sample_point = 1'b0;
		seen_done    = 1'b0;
		seen_error   = 1'b0;
		seen_kind    = can_pkg::ERR_NONE;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (3) drive_bit(1'b1);
		test_base_data_frame();
		test_extended_remote_frame();
		test_dlc_clamp();
		test_crc_error();
		test_stuff_error_recovery();
		test_form_error();
		$display("Tests run %0d, tests failed %0d, check errors %0d",
			test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verilog/can_rx_decoder.sv
`timescale 1ns/1ns

module can_rx_decoder #(
	parameter int MAX_DATA_BYTES = 8
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         rx_bit,        // Bus level
	input  logic                         sample_point,  // One clock per bit time
	output logic [can_pkg::LEN_ID_A-1:0] id_a,
	output logic [can_pkg::LEN_ID_B-1:0] id_b,
	output logic                         ide,
	output logic                         srr,
	output logic                         rtr,
	output logic [can_pkg::LEN_DLC-1:0]  dlc,           // Clamped
	output logic [8*MAX_DATA_BYTES-1:0]  data,
	output logic [can_pkg::LEN_CRC-1:0]  crc_received,
	output logic                         frame_done,
	output logic                         frame_error,
	output can_pkg::error_kind_t         error_kind
);

	logic                        data_bit_valid;
	logic                        stuff_error;
	logic                        stuff_check;
	logic                        crc_shift;
	logic                        frame_start;
	can_pkg::field_sel_t         field_sel;
	logic [can_pkg::LEN_CRC-1:0] crc_calc;

	// ======================================================================
	// Bit-serial receive chain
	// ======================================================================
	can_destuff can_destuff_inst (
		.clock          (clock),
		.reset          (reset),
		.rx_bit         (rx_bit),
		.sample_point   (sample_point),
		.stuff_check    (stuff_check),
		.data_bit_valid (data_bit_valid),
		.stuff_error    (stuff_error)
	);

	can_crc15 can_crc15_inst (
		.clock       (clock),
		.reset       (reset),
		.rx_bit      (rx_bit),
		.crc_shift   (crc_shift),
		.frame_start (frame_start),
		.crc_calc    (crc_calc)
	);

	can_frame_fsm #(
		.MAX_DATA_BYTES (MAX_DATA_BYTES)
	) can_frame_fsm_inst (
		.clock          (clock),
		.reset          (reset),
		.rx_bit         (rx_bit),
		.sample_point   (sample_point),
		.data_bit_valid (data_bit_valid),
		.stuff_error    (stuff_error),
		.dlc_clamped    (dlc),           // Same net as the output
		.rtr            (rtr),
		.crc_calc       (crc_calc),
		.crc_received   (crc_received),
		.stuff_check    (stuff_check),
		.field_sel      (field_sel),
		.crc_shift      (crc_shift),
		.frame_start    (frame_start),
		.frame_done     (frame_done),
		.frame_error    (frame_error),
		.error_kind     (error_kind)
	);

	can_field_capture #(
		.MAX_DATA_BYTES (MAX_DATA_BYTES)
	) can_field_capture_inst (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.field_sel    (field_sel),
		.frame_start  (frame_start),
		.id_a         (id_a),
		.id_b         (id_b),
		.ide          (ide),
		.srr          (srr),
		.rtr          (rtr),
		.dlc_clamped  (dlc),
		.data         (data),
		.crc_received (crc_received)
	);

endmodule

// File: verilog/can_field_capture.sv
`timescale 1ns/1ns

module can_field_capture #(
	parameter int MAX_DATA_BYTES = 8
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             rx_bit,
	input  can_pkg::field_sel_t              field_sel,    // Only on data bits
	input  logic                             frame_start,
	output logic [can_pkg::LEN_ID_A-1:0]     id_a,
	output logic [can_pkg::LEN_ID_B-1:0]     id_b,
	output logic                             ide,
	output logic                             srr,
	output logic                             rtr,
	output logic [can_pkg::LEN_DLC-1:0]      dlc_clamped,
	output logic [8*MAX_DATA_BYTES-1:0]      data,
	output logic [can_pkg::LEN_CRC-1:0]      crc_received
);

	localparam int DATA_W = 8 * MAX_DATA_BYTES;
	localparam int DLC_W  = can_pkg::LEN_DLC;

	logic [DLC_W-1:0] dlc_raw;  // DLC as sent

	// ======================================================================
	// Control fields, read back by the FSM
	// ======================================================================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			ide     <= 1'b0;
			srr     <= 1'b0;
			rtr     <= 1'b0;
			dlc_raw <= '0;
		end
		else if (frame_start)
		begin
			ide     <= 1'b0;
			srr     <= 1'b0;
			rtr     <= 1'b0;
			dlc_raw <= '0;
		end
		else
		begin
			case (field_sel)
				can_pkg::SEL_RTR_SRR:
				begin
					rtr <= rx_bit;  // RTR if the frame turns out base
					srr <= 1'b0;
				end
				can_pkg::SEL_IDE:
				begin
					ide <= rx_bit;
					if (rx_bit)
						srr <= rtr;  // Extended, that bit was SRR
				end
				can_pkg::SEL_RTR_EXT: rtr     <= rx_bit;  // Real RTR of extended frame
				can_pkg::SEL_DLC:     dlc_raw <= {dlc_raw[DLC_W-2:0], rx_bit};
				default:              ;
			endcase
		end
	end

	// ======================================================================
	// Payload shift registers, MSB first
	// ======================================================================
	always_ff @(posedge clock)
	begin
		if (frame_start)
		begin
			id_a         <= '0;
			id_b         <= '0;
			data         <= '0;
			crc_received <= '0;
		end
		else
		begin
			case (field_sel)
				can_pkg::SEL_ID_A: id_a <= {id_a[can_pkg::LEN_ID_A-2:0], rx_bit};
				can_pkg::SEL_ID_B: id_b <= {id_b[can_pkg::LEN_ID_B-2:0], rx_bit};
				can_pkg::SEL_DATA: data <= {data[DATA_W-2:0], rx_bit};  // Last byte lowest
				can_pkg::SEL_CRC:
					crc_received <= {crc_received[can_pkg::LEN_CRC-2:0], rx_bit};
				default: ;
			endcase
		end
	end

	// DLC 9 to 15 still means the largest payload
	assign dlc_clamped = (dlc_raw > MAX_DATA_BYTES) ? DLC_W'(MAX_DATA_BYTES) : dlc_raw;

	// SOF clear never swallows a field bit
	assert property (@(posedge clock) disable iff (reset)
		frame_start |-> (field_sel == can_pkg::SEL_NONE));

endmodule

// File: verilog/can_frame_fsm.sv
`timescale 1ns/1ns

module can_frame_fsm #(
	parameter int MAX_DATA_BYTES = 8
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        rx_bit,
	input  logic                        sample_point,
	input  logic                        data_bit_valid,
	input  logic                        stuff_error,
	input  logic [can_pkg::LEN_DLC-1:0] dlc_clamped,
	input  logic                        rtr,
	input  logic [can_pkg::LEN_CRC-1:0] crc_calc,
	input  logic [can_pkg::LEN_CRC-1:0] crc_received,
	output logic                        stuff_check,
	output can_pkg::field_sel_t         field_sel,
	output logic                        crc_shift,
	output logic                        frame_start,
	output logic                        frame_done,
	output logic                        frame_error,
	output can_pkg::error_kind_t        error_kind
);

	localparam int CNT_W = $clog2(8 * MAX_DATA_BYTES + 32);  // Data field and id_b fit

	can_pkg::frame_state_t state;
	can_pkg::frame_state_t next_state;
	logic [CNT_W-1:0]      bit_cnt;    // Bits seen in the current state
	logic [CNT_W-1:0]      cnt_next;
	logic [CNT_W-1:0]      data_bits;  // Length of the data field
	logic                  form_bad;
	logic                  crc_bad;
	logic                  flag_bad;
	logic                  err_hit;
	logic                  done_hit;
	can_pkg::error_kind_t  err_code;

	// ======================================================================
	// Strobes to the datapath
	// ======================================================================
	assign data_bits   = CNT_W'(dlc_clamped) << 3;  // Eight bits per byte
	assign stuff_check = state inside {[can_pkg::ST_ID_A : can_pkg::ST_CRC_DELIM]};
	assign crc_shift   = data_bit_valid && (state inside {[can_pkg::ST_ID_A : can_pkg::ST_DATA]});
	assign frame_start = sample_point && (state == can_pkg::ST_IDLE) && !rx_bit;

	always_comb
	begin
		field_sel = can_pkg::SEL_NONE;
		if (data_bit_valid)
		begin
			case (state)
				can_pkg::ST_ID_A:    field_sel = can_pkg::SEL_ID_A;
				can_pkg::ST_RTR_SRR: field_sel = can_pkg::SEL_RTR_SRR;
				can_pkg::ST_IDE:     field_sel = can_pkg::SEL_IDE;
				can_pkg::ST_ID_B:    field_sel = can_pkg::SEL_ID_B;
				can_pkg::ST_RTR:     field_sel = can_pkg::SEL_RTR_EXT;
				can_pkg::ST_DLC:     field_sel = can_pkg::SEL_DLC;
				can_pkg::ST_DATA:    field_sel = can_pkg::SEL_DATA;
				can_pkg::ST_CRC:     field_sel = can_pkg::SEL_CRC;
				default:             field_sel = can_pkg::SEL_NONE;  // Reserved bits, tail
			endcase
		end
	end

	// ======================================================================
	// Next state and error detection
	// ======================================================================
	always_comb
	begin
		next_state = state;
		cnt_next   = bit_cnt;  // Stuff bits leave the count alone
		form_bad   = 1'b0;
		crc_bad    = 1'b0;
		flag_bad   = 1'b0;
		done_hit   = 1'b0;
		if (data_bit_valid)
		begin
			cnt_next = bit_cnt + 1'b1;
			case (state)
				can_pkg::ST_IDLE:
					if (!rx_bit)
						next_state = can_pkg::ST_ID_A;  // SOF
				can_pkg::ST_ID_A:
					if (bit_cnt == CNT_W'(can_pkg::LEN_ID_A - 1))
						next_state = can_pkg::ST_RTR_SRR;
				can_pkg::ST_RTR_SRR:
					next_state = can_pkg::ST_IDE;
				can_pkg::ST_IDE:
					if (!rx_bit)
						next_state = can_pkg::ST_RESERVED0;  // Base frame
					else if (!rtr)
						form_bad = 1'b1;  // SRR must be recessive
					else
						next_state = can_pkg::ST_ID_B;
				can_pkg::ST_ID_B:
					if (bit_cnt == CNT_W'(can_pkg::LEN_ID_B - 1))
						next_state = can_pkg::ST_RTR;
				can_pkg::ST_RTR:
					next_state = can_pkg::ST_RESERVED1;
				can_pkg::ST_RESERVED1:
					next_state = can_pkg::ST_RESERVED0;
				can_pkg::ST_RESERVED0:
					next_state = can_pkg::ST_DLC;
				can_pkg::ST_DLC:
					// Last DLC bit still on the bus; clamp keeps zero as zero
					if (bit_cnt == CNT_W'(can_pkg::LEN_DLC - 1))
					begin
						if (rtr || (dlc_clamped == '0 && !rx_bit))
							next_state = can_pkg::ST_CRC;  // No data field
						else
							next_state = can_pkg::ST_DATA;
					end
				can_pkg::ST_DATA:
					if (bit_cnt == data_bits - 1'b1)
						next_state = can_pkg::ST_CRC;
				can_pkg::ST_CRC:
					if (bit_cnt == CNT_W'(can_pkg::LEN_CRC - 1))
						next_state = can_pkg::ST_CRC_DELIM;
				can_pkg::ST_CRC_DELIM:
					if (!rx_bit)
						form_bad = 1'b1;
					else
						next_state = can_pkg::ST_ACK_SLOT;
				can_pkg::ST_ACK_SLOT:
					next_state = can_pkg::ST_ACK_DELIM;  // Either level accepted
				can_pkg::ST_ACK_DELIM:
				begin
					crc_bad  = (crc_calc != crc_received);  // Checked here per spec
					form_bad = !rx_bit;
					next_state = can_pkg::ST_EOF;
				end
				can_pkg::ST_EOF:
					if (!rx_bit)
						form_bad = 1'b1;
					else if (bit_cnt == CNT_W'(can_pkg::LEN_EOF - 1))
					begin
						done_hit   = 1'b1;
						next_state = can_pkg::ST_INTERMISSION;
					end
				can_pkg::ST_INTERMISSION:
					if (!rx_bit)
						form_bad = 1'b1;  // No overload frames here
					else if (bit_cnt == CNT_W'(can_pkg::LEN_INTERMISSION - 1))
						next_state = can_pkg::ST_IDLE;
				can_pkg::ST_ERROR_FLAGS:
					if (rx_bit)
					begin
						if (bit_cnt < CNT_W'(can_pkg::FLAGS_MIN))
							flag_bad = 1'b1;  // Flag too short
						else
							next_state = can_pkg::ST_ERROR_DELIM;
					end
					else if (bit_cnt >= CNT_W'(can_pkg::FLAGS_MAX))
						flag_bad = 1'b1;  // Thirteenth dominant bit
				can_pkg::ST_ERROR_DELIM:
					if (!rx_bit)
						form_bad = 1'b1;
					else if (bit_cnt == CNT_W'(can_pkg::LEN_DELIM - 1))
						next_state = can_pkg::ST_INTERMISSION;
				default:
					next_state = can_pkg::ST_IDLE;
			endcase
		end

		err_hit  = stuff_error || form_bad || crc_bad || flag_bad;
		err_code = stuff_error ? can_pkg::ERR_STUFF :
			crc_bad ? can_pkg::ERR_CRC :
			flag_bad ? can_pkg::ERR_FLAG :
			form_bad ? can_pkg::ERR_FORM : can_pkg::ERR_NONE;

		if (err_hit)
		begin
			next_state = can_pkg::ST_ERROR_FLAGS;  // Flag starts on the next bit
			cnt_next   = '0;
		end
		else if (next_state != state)
			// First recessive bit after the flag is delimiter bit one
			cnt_next = (next_state == can_pkg::ST_ERROR_DELIM) ? CNT_W'(1) : '0;
	end

	// ======================================================================
	// State register and output pulses
	// ======================================================================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state       <= can_pkg::ST_IDLE;
			bit_cnt     <= '0;
			frame_done  <= 1'b0;
			frame_error <= 1'b0;
			error_kind  <= can_pkg::ERR_NONE;
		end
		else
		begin
			frame_done  <= done_hit;  // One clock, tied to the sample
			frame_error <= err_hit;
			if (sample_point)
			begin
				state   <= next_state;
				bit_cnt <= cnt_next;
			end
			if (err_hit)
				error_kind <= err_code;
			else if (frame_start)
				error_kind <= can_pkg::ERR_NONE;  // Held until the next SOF
		end
	end

	// A frame either completes or fails, never both on one bit
	assert property (@(posedge clock) disable iff (reset) !(frame_done && frame_error));

endmodule

// File: verilog/can_crc15.sv
`timescale 1ns/1ns

module can_crc15 (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        rx_bit,
	input  logic                        crc_shift,    // Destuffed bit inside the CRC span
	input  logic                        frame_start,  // SOF sample
	output logic [can_pkg::LEN_CRC-1:0] crc_calc
);

	localparam int CRC_W = can_pkg::LEN_CRC;

	logic feedback;

	// Standard CAN LFSR, MSB first
	assign feedback = rx_bit ^ crc_calc[CRC_W-1];

	// SOF is dominant and the register is zero, so skipping SOF changes nothing
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_calc <= '0;
		else if (frame_start)
			crc_calc <= '0;  // Fresh sum per frame
		else if (crc_shift)
		begin
			if (feedback)
				crc_calc <= {crc_calc[CRC_W-2:0], 1'b0} ^ can_pkg::CRC_POLY;
			else
				crc_calc <= {crc_calc[CRC_W-2:0], 1'b0};
		end
	end

endmodule

// File: verilog/can_destuff.sv
`timescale 1ns/1ns

module can_destuff (
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	input  logic stuff_check,     // High from identifier to CRC delimiter
	output logic data_bit_valid,  // Sample carries frame content
	output logic stuff_error      // Sixth equal bit
);

	localparam int HIST_W = can_pkg::STUFF_RUN;

	logic [HIST_W-1:0] history;  // Last samples, newest in bit 0
	logic              run_low;
	logic              run_high;
	logic              stuff_bit;

	// Every sample counts, stuff bits too, since a stuff bit starts a new run
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= HIST_W'(5'b10101);  // Alternating, no run pending
		else if (sample_point)
			history <= {history[HIST_W-2:0], rx_bit};
	end

	assign run_low  = (history == '0);  // Five dominant
	assign run_high = (history == '1);  // Five recessive

	// Opposite level after a run, dropped from the frame
	assign stuff_bit = stuff_check && ((run_low && rx_bit) || (run_high && !rx_bit));

	// Same level after a run breaks the stuffing rule
	assign stuff_error = sample_point && stuff_check &&
		((run_low && !rx_bit) || (run_high && rx_bit));

	// Outside the stuffed region every sample is a data bit
	assign data_bit_valid = sample_point && !stuff_bit && !stuff_error;

	// One strobe per bit time, so the history shifts once per bit
	assert property (@(posedge clock) disable iff (reset)
		sample_point |=> !sample_point);

endmodule

// File: verilog/can_pkg.sv
package can_pkg;

	// ======================================================================
	// Field lengths, in bits
	// ======================================================================
	localparam int LEN_ID_A         = 11;  // Base identifier
	localparam int LEN_ID_B         = 18;  // Identifier extension
	localparam int LEN_DLC          = 4;
	localparam int LEN_CRC          = 15;
	localparam int LEN_EOF          = 7;   // Recessive end of frame
	localparam int LEN_INTERMISSION = 2;   // Third bit may already be the next SOF
	localparam int STUFF_RUN        = 5;   // Equal bits before a stuff bit
	localparam int FLAGS_MIN        = 6;   // Error flag, dominant
	localparam int FLAGS_MAX        = 12;  // Six own plus six echoed
	localparam int LEN_DELIM        = 8;   // Error delimiter, recessive

	// x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	localparam logic [LEN_CRC-1:0] CRC_POLY = 15'h4599;

	// ======================================================================
	// Enumerations
	// ======================================================================
	// Order matters, range tests in the FSM rely on it
	typedef enum logic [4:0] {
		ST_IDLE, ST_ID_A, ST_RTR_SRR, ST_IDE, ST_ID_B, ST_RTR,
		ST_RESERVED1, ST_RESERVED0, ST_DLC, ST_DATA, ST_CRC, ST_CRC_DELIM,
		ST_ACK_SLOT, ST_ACK_DELIM, ST_EOF, ST_INTERMISSION,
		ST_ERROR_FLAGS, ST_ERROR_DELIM
	} frame_state_t;

	// Capture register that takes the current data bit
	typedef enum logic [3:0] {
		SEL_NONE, SEL_ID_A, SEL_RTR_SRR, SEL_IDE, SEL_ID_B,
		SEL_RTR_EXT, SEL_DLC, SEL_DATA, SEL_CRC
	} field_sel_t;

	// Cause of the last error
	typedef enum logic [2:0] {
		ERR_NONE, ERR_STUFF, ERR_FORM, ERR_CRC, ERR_FLAG
	} error_kind_t;

endpackage
